//--- project.f
+incdir+rtl
rtl/ines_pkg.sv
rtl/ines_header_decode.sv
rtl/load_counter.sv
rtl/loader_fsm.sv
rtl/wb_write_master.sv
rtl/game_loader.sv
tests/game_loader_assert.sv
tests/game_loader_tb.sv

//--- rtl/game_loader.sv
// ****************************************
// NES cartridge image loader, top level
// Takes an iNES file as a byte stream and writes
// PRG and CHR data to memory over Wishbone
// ****************************************
`timescale 1ns/100ps

module game_loader import ines_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          download,
	input  logic [7:0]    in_data,
	input  logic          in_valid,
	output logic          in_ready,
	input  logic          invert_mirroring,
	output wb_req_t       wb_req,
	input  logic          wb_ack,
	output logic          busy,
	output logic          done,
	output logic          error,
	output mapper_flags_t mapper_flags
);

	logic       restart;
	logic       hdr_wr;
	logic       hdr_complete;
	logic       hdr_ok;
	logic [7:0] prg_pages;
	logic [7:0] chr_pages;
	logic       cnt_load_prg;
	logic       cnt_load_chr;
	logic       cnt_step;
	logic       count_zero;
	mem_addr_t  addr;
	logic       wr_start;
	logic       wr_idle;

	loader_fsm fsm_i (
		.clk          (clk),
		.reset        (reset),
		.download     (download),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.hdr_complete (hdr_complete),
		.hdr_ok       (hdr_ok),
		.count_zero   (count_zero),
		.wr_idle      (wr_idle),
		.restart      (restart),
		.hdr_wr       (hdr_wr),
		.cnt_load_prg (cnt_load_prg),
		.cnt_load_chr (cnt_load_chr),
		.cnt_step     (cnt_step),
		.wr_start     (wr_start),
		.busy         (busy),
		.done         (done),
		.error        (error)
	);

	ines_header_decode header_i (
		.clk              (clk),
		.reset            (reset),
		.clear            (restart),
		.hdr_wr           (hdr_wr),
		.in_data          (in_data),
		.invert_mirroring (invert_mirroring),
		.hdr_complete     (hdr_complete),
		.hdr_ok           (hdr_ok),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.mapper_flags     (mapper_flags)
	);

	load_counter counter_i (
		.clk          (clk),
		.reset        (reset),
		.cnt_load_prg (cnt_load_prg),
		.cnt_load_chr (cnt_load_chr),
		.cnt_step     (cnt_step),
		.prg_pages    (prg_pages),
		.chr_pages    (chr_pages),
		.addr         (addr),
		.count_zero   (count_zero)
	);

	// Memory side
	wb_write_master wb_i (
		.clk      (clk),
		.reset    (reset),
		.wr_start (wr_start),
		.addr     (addr),
		.in_data  (in_data),
		.wb_ack   (wb_ack),
		.wb_req   (wb_req),
		.wr_idle  (wr_idle)
	);

endmodule

//--- rtl/ines_header_decode.sv
// ****************************************
// iNES header store and decoder
// Collects the 16 header bytes, checks them and
// produces page counts and the mapper flag word
// ****************************************
`timescale 1ns/100ps
`include "ines_macros.svh"

module ines_header_decode import ines_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          clear,
	input  logic          hdr_wr,
	input  logic [7:0]    in_data,
	input  logic          invert_mirroring,
	output logic          hdr_complete,
	output logic          hdr_ok,
	output logic [7:0]    prg_pages,
	output logic [7:0]    chr_pages,
	output mapper_flags_t mapper_flags
);

	localparam int IDX_W = $clog2(`INES_HEADER_BYTES + 1);
	localparam int SEL_W = $clog2(`INES_HEADER_BYTES);

	logic [7:0]       hdr_mem [`INES_HEADER_BYTES];
	logic [IDX_W-1:0] idx;
	logic             is_nes20;
	logic             tail_nz;
	logic             is_dirty;

	assign hdr_complete = (idx == IDX_W'(`INES_HEADER_BYTES));

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			idx <= '0;
		end else if (hdr_wr && !hdr_complete) begin
			idx <= idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_wr && !hdr_complete && !clear)
			hdr_mem[idx[SEL_W-1:0]] <= in_data;
	end

	// "NES" + EOF, and no trainer block
	assign hdr_ok = (hdr_mem[0] == `INES_MAGIC0) && (hdr_mem[1] == `INES_MAGIC1) &&
		(hdr_mem[2] == `INES_MAGIC2) && (hdr_mem[3] == `INES_MAGIC3) && !hdr_mem[6][2];

	assign prg_pages = hdr_mem[4];
	assign chr_pages = hdr_mem[5]; // Zero means CHR RAM

	assign is_nes20 = (hdr_mem[7][3:2] == 2'b10);

	// Old dumps often carry junk in the unused tail
	always_comb begin
		tail_nz = |hdr_mem[9][7:1];
		for (int i = 10; i < `INES_HEADER_BYTES; i++) begin
			tail_nz = tail_nz | (|hdr_mem[i]);
		end
	end

	assign is_dirty = !is_nes20 && tail_nz;

	always_comb begin
		mapper_flags.submapper   = is_nes20 ? hdr_mem[8] : 8'h00;
		mapper_flags.four_screen = hdr_mem[6][3];
		mapper_flags.chr_ram     = (chr_pages == 8'd0);
		mapper_flags.mirroring   = hdr_mem[6][0] ^ invert_mirroring;
		mapper_flags.chr_size    = size_code(chr_pages);
		mapper_flags.prg_size    = size_code(prg_pages);
		mapper_flags.mapper      = {is_dirty ? 4'h0 : hdr_mem[7][7:4], hdr_mem[6][7:4]};
	end

endmodule

//--- rtl/ines_macros.svh
// ****************************************
// Constants of the iNES image loader
// Include in any file that needs header sizes,
// page shifts or memory base addresses
// ****************************************
`ifndef INES_MACROS_SVH
`define INES_MACROS_SVH

// iNES header
`define INES_HEADER_BYTES 16
`define INES_MAGIC0 8'h4E // 'N'
`define INES_MAGIC1 8'h45 // 'E'
`define INES_MAGIC2 8'h53 // 'S'
`define INES_MAGIC3 8'h1A // MS-DOS EOF

// Memory layout
`define MEM_ADDR_W 22
`define PRG_PAGE_SHIFT 14 // 16 KiB PRG pages
`define CHR_PAGE_SHIFT 13 // 8 KiB CHR pages
`define PRG_BASE_ADDR 22'h000000
`define CHR_BASE_ADDR 22'h200000

`endif

//--- rtl/ines_pkg.sv
// ****************************************
// Shared types of the iNES image loader
// Import into modules that use states, flags or bus types
// ****************************************
`include "ines_macros.svh"

package ines_pkg;

	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

	typedef enum logic [2:0] {
		st_header,
		st_prg,
		st_chr,
		st_done,
		st_error
	} loader_state_t;

	// Cartridge description handed to the NES core
	typedef struct packed {
		logic [7:0] submapper;   // iNES 2.0 only
		logic       four_screen;
		logic       chr_ram;     // No CHR ROM in the image
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	// Wishbone classic master request, byte wide
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		mem_addr_t adr;
		logic [7:0] dat;
	} wb_req_t;

	// Smallest k with pages <= 2**k, 7 when above 64
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (pages <= (8'd1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

endpackage

//--- rtl/load_counter.sv
// ****************************************
// Byte and address counters for PRG and CHR loading
// Loaded at each phase change, stepped per written byte
// ****************************************
`timescale 1ns/100ps
`include "ines_macros.svh"

module load_counter import ines_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cnt_load_prg,
	input  logic       cnt_load_chr,
	input  logic       cnt_step,
	input  logic [7:0] prg_pages,
	input  logic [7:0] chr_pages,
	output mem_addr_t  addr,
	output logic       count_zero
);

	mem_addr_t bytes_left;
	mem_addr_t prg_bytes;
	mem_addr_t chr_bytes;

	// Page counts scaled to bytes
	assign prg_bytes = mem_addr_t'({prg_pages, {`PRG_PAGE_SHIFT{1'b0}}});
	assign chr_bytes = mem_addr_t'({chr_pages, {`CHR_PAGE_SHIFT{1'b0}}});

	always_ff @(posedge clk) begin
		if (reset) begin
			bytes_left <= '0;
			addr       <= '0;
		end else if (cnt_load_prg) begin
			bytes_left <= prg_bytes;
			addr       <= `PRG_BASE_ADDR;
		end else if (cnt_load_chr) begin
			bytes_left <= chr_bytes;
			addr       <= `CHR_BASE_ADDR;
		end else if (cnt_step) begin
			bytes_left <= bytes_left - 1'b1;
			addr       <= addr + 1'b1;
		end
	end

	assign count_zero = (bytes_left == '0);

endmodule

//--- rtl/loader_fsm.sv
// ****************************************
// Loader sequencer
// Walks header, PRG, CHR and the end states,
// paces the byte input and drives the other blocks
// ****************************************
`timescale 1ns/100ps

module loader_fsm import ines_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic download,
	input  logic in_valid,
	output logic in_ready,
	input  logic hdr_complete,
	input  logic hdr_ok,
	input  logic count_zero,
	input  logic wr_idle,
	output logic restart,
	output logic hdr_wr,
	output logic cnt_load_prg,
	output logic cnt_load_chr,
	output logic cnt_step,
	output logic wr_start,
	output logic busy,
	output logic done,
	output logic error
);

	loader_state_t state;
	logic          download_q;
	logic          accept;
	logic          in_load;
	logic          phase_end;

	assign restart = download && !download_q; // New file starts

	assign in_load   = (state == st_prg) || (state == st_chr);
	assign phase_end = in_load && count_zero && wr_idle;

	// One byte in flight at a time while loading
	always_comb begin
		case (state)
			st_header: in_ready = !hdr_complete;
			st_prg,
			st_chr:    in_ready = wr_idle && !count_zero;
			default:   in_ready = 1'b1; // Drop trailing bytes
		endcase
		if (restart)
			in_ready = 1'b0;
	end

	assign accept = in_valid && in_ready;

	assign hdr_wr   = accept && (state == st_header);
	assign wr_start = accept && in_load;
	assign cnt_step = wr_start;

	assign cnt_load_prg = (state == st_header) && hdr_complete && hdr_ok;
	assign cnt_load_chr = (state == st_prg) && phase_end;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= st_header;
			download_q <= 1'b0;
		end else begin
			download_q <= download;
			if (restart) begin
				state <= st_header;
			end else begin
				case (state)
					st_header: begin
						if (hdr_complete)
							state <= hdr_ok ? st_prg : st_error;
					end
					st_prg: begin
						if (phase_end)
							state <= st_chr;
					end
					st_chr: begin
						if (phase_end)
							state <= st_done;
					end
					default: state <= state; // Wait for the next download
				endcase
			end
		end
	end

	// Status follows the state directly
	assign busy  = in_load || ((state == st_header) && hdr_complete);
	assign done  = (state == st_done) || (state == st_error);
	assign error = (state == st_error);

endmodule

//--- rtl/wb_write_master.sv
// ****************************************
// Wishbone classic single write master
// Pulse wr_start with address and byte valid,
// wr_idle returns high after the ack
// ****************************************
`timescale 1ns/100ps

module wb_write_master import ines_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       wr_start,
	input  mem_addr_t  addr,
	input  logic [7:0] in_data,
	input  logic       wb_ack,
	output wb_req_t    wb_req,
	output logic       wr_idle
);

	wb_req_t req;

	always_ff @(posedge clk) begin
		if (reset) begin
			req <= '0;
		end else if (req.stb) begin
			if (wb_ack) begin // Slave took the byte
				req.cyc <= 1'b0;
				req.stb <= 1'b0;
				req.we  <= 1'b0;
			end
		end else if (wr_start) begin
			req.cyc <= 1'b1;
			req.stb <= 1'b1;
			req.we  <= 1'b1;
			req.adr <= addr;
			req.dat <= in_data;
		end
	end

	assign wb_req  = req;
	assign wr_idle = !req.cyc;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the loader testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module game_loader_tb -Mdir obj_dir \
	&& ./obj_dir/Vgame_loader_tb \
	|| { echo "run.sh: simulation did not pass"; exit 1; }

//--- tests/game_loader_assert.sv
// ****************************************
// Bus and status assertions of the loader
// Bound to the top level of the loader
// ****************************************
`timescale 1ns/100ps

module game_loader_assert import ines_pkg::*; (
	input logic    clk,
	input logic    reset,
	input wb_req_t wb_req,
	input logic    wb_ack,
	input logic    in_ready,
	input logic    busy,
	input logic    done
);

	stb_has_cyc: assert property (@(posedge clk) disable iff (reset)
		wb_req.stb |-> wb_req.cyc)
		else $error("stb without cyc");

	// Address and data held until the slave acks
	req_stable: assert property (@(posedge clk) disable iff (reset)
		(wb_req.stb && !wb_ack) |=> ($stable(wb_req.adr) && $stable(wb_req.dat)))
		else $error("adr or dat changed while waiting for ack");

	no_ready_in_write: assert property (@(posedge clk) disable iff (reset)
		wb_req.stb |-> !in_ready)
		else $error("in_ready high during a bus write");

	done_not_busy: assert property (@(posedge clk) disable iff (reset)
		!(done && busy))
		else $error("done and busy high together");

endmodule

bind game_loader game_loader_assert assert_i (.*);

//--- tests/game_loader_tb.sv
// ****************************************
// Testbench of the iNES image loader
// Streams images into the DUT, models the memory
// and checks every write, the flags and the status
// ****************************************
`timescale 1ns/100ps
`include "ines_macros.svh"

module game_loader_tb import ines_pkg::*; ();

	localparam int PRG_BYTES   = 1 << `PRG_PAGE_SHIFT;
	localparam int CHR_BYTES   = 1 << `CHR_PAGE_SHIFT;
	localparam int FILE_1_1    = `INES_HEADER_BYTES + PRG_BYTES + CHR_BYTES;
	localparam int TOTAL_BYTES = 4 * FILE_1_1 + PRG_BYTES + 2 * (`INES_HEADER_BYTES + 32)
		+ `INES_HEADER_BYTES + PRG_BYTES;
	localparam int WATCHDOG_NS = TOTAL_BYTES * 6 * 10 + 100000;

	logic          clk = 1'b0;
	logic          reset;
	logic          download;
	logic [7:0]    in_data;
	logic          in_valid;
	logic          in_ready;
	logic          invert_mirroring;
	wb_req_t       wb_req;
	logic          wb_ack;
	logic          busy;
	logic          done;
	logic          error;
	mapper_flags_t mapper_flags;

	logic [31:0] rng = 32'h1104;
	logic [7:0]  hdr [16];
	mem_addr_t   exp_adr[$];
	logic [7:0]  exp_dat[$];
	mem_addr_t   got_adr[$];
	logic [7:0]  got_dat[$];
	logic        ack_pending;
	logic [1:0]  ack_delay;

	game_loader dut_i (.*);

	always #5 clk = ~clk;

	function automatic logic [7:0] rand_byte();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng[23:16];
	endfunction

	function automatic logic [2:0] size_code_of(input logic [7:0] pages);
		for (int k = 0; k <= 6; k++) begin
			if (int'(pages) <= (1 << k))
				return 3'(k);
		end
		return 3'd7;
	endfunction

	// Expected flag word straight from the header rules
	function automatic mapper_flags_t ref_flags(input logic [7:0] h [16], input logic inv);
		mapper_flags_t f;
		logic          nes20;
		logic          junk;
		nes20 = (h[7][3:2] == 2'b10);
		junk = (h[9][7:1] != 7'd0);
		for (int i = 10; i < 16; i++)
			junk = junk || (h[i] != 8'd0);
		f.submapper   = nes20 ? h[8] : 8'd0;
		f.four_screen = h[6][3];
		f.chr_ram     = (h[5] == 8'd0);
		f.mirroring   = h[6][0] ^ inv;
		f.chr_size    = size_code_of(h[5]);
		f.prg_size    = size_code_of(h[4]);
		f.mapper      = {(!nes20 && junk) ? 4'd0 : h[7][7:4], h[6][7:4]};
		return f;
	endfunction

	task automatic report_error(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic write_compare(input mem_addr_t ea, input logic [7:0] ed,
			input mem_addr_t ga, input logic [7:0] gd);
		if (ga !== ea || gd !== ed)
			report_error($sformatf("write %h=%h, expected %h=%h", ga, gd, ea, ed));
	endtask

	task automatic verify_flags(input mapper_flags_t expected, input mapper_flags_t got);
		if (got !== expected)
			report_error($sformatf("mapper_flags %h, expected %h", got, expected));
	endtask

	task automatic status_check(input logic eb, input logic ed, input logic ee);
		if (busy !== eb || done !== ed || error !== ee)
			report_error($sformatf("busy/done/error %b%b%b, expected %b%b%b",
				busy, done, error, eb, ed, ee));
	endtask

	// Memory model, acks after 0 to 3 cycles
	always @(negedge clk) begin
		if (reset) begin
			wb_ack = 1'b0;
			ack_pending = 1'b0;
		end else if (wb_ack) begin
			wb_ack = 1'b0; // Taken at the last rising edge
		end else if (wb_req.stb) begin
			if (!wb_req.cyc || !wb_req.we)
				report_error("bus request without cyc or we");
			if (!ack_pending) begin
				ack_pending = 1'b1;
				ack_delay = 2'(rand_byte());
			end
			if (ack_delay == 2'd0) begin
				wb_ack = 1'b1;
				ack_pending = 1'b0;
				got_adr.push_back(wb_req.adr);
				got_dat.push_back(wb_req.dat);
			end else begin
				ack_delay = ack_delay - 1'b1;
			end
		end
	end

	// Compare finished writes in order
	always @(negedge clk) begin
		while (got_adr.size() > 0) begin
			if (exp_adr.size() == 0)
				report_error($sformatf("unexpected write to %h", got_adr[0]));
			write_compare(exp_adr.pop_front(), exp_dat.pop_front(),
				got_adr.pop_front(), got_dat.pop_front());
		end
	end

	task automatic send_byte(input logic [7:0] b);
		if (2'(rand_byte()) == 2'd0) begin // Input gap
			in_valid = 1'b0;
			@(negedge clk);
		end
		in_valid = 1'b1;
		in_data  = b;
		while (!in_ready)
			@(negedge clk);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic set_header(input logic [7:0] prg, input logic [7:0] chr,
			input logic [7:0] f6, input logic [7:0] f7, input logic [7:0] f8,
			input logic [7:0] b12);
		hdr[0] = `INES_MAGIC0;
		hdr[1] = `INES_MAGIC1;
		hdr[2] = `INES_MAGIC2;
		hdr[3] = `INES_MAGIC3;
		hdr[4] = prg;
		hdr[5] = chr;
		hdr[6] = f6;
		hdr[7] = f7;
		hdr[8] = f8;
		for (int i = 9; i < 16; i++)
			hdr[i] = 8'd0;
		hdr[12] = b12;
	endtask

	task automatic load_file(input logic good);
		logic [7:0] d;
		@(negedge clk);
		download = 1'b0;
		@(negedge clk);
		download = 1'b1; // Rising edge restarts the loader
		@(negedge clk); // Restart cycle holds in_ready low
		for (int i = 0; i < 16; i++)
			send_byte(hdr[i]);
		status_check(1'b1, 1'b0, 1'b0);
		if (good) begin
			for (int i = 0; i < int'(hdr[4]) * PRG_BYTES; i++) begin
				d = rand_byte();
				exp_adr.push_back(`PRG_BASE_ADDR + mem_addr_t'(i));
				exp_dat.push_back(d);
				send_byte(d);
			end
			for (int i = 0; i < int'(hdr[5]) * CHR_BYTES; i++) begin
				d = rand_byte();
				exp_adr.push_back(`CHR_BASE_ADDR + mem_addr_t'(i));
				exp_dat.push_back(d);
				send_byte(d);
			end
		end else begin
			for (int i = 0; i < 32; i++)
				send_byte(rand_byte()); // Dropped by the loader
		end
		while (!done)
			@(negedge clk);
		repeat (2) @(negedge clk);
		status_check(1'b0, 1'b1, !good);
		if (exp_adr.size() != 0)
			report_error($sformatf("%0d writes missing", exp_adr.size()));
		if (good)
			verify_flags(ref_flags(hdr, invert_mirroring), mapper_flags);
	endtask

	initial begin
		reset = 1'b1;
		download = 1'b0;
		in_data = 8'd0;
		in_valid = 1'b0;
		invert_mirroring = 1'b0;
		wb_ack = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		status_check(1'b0, 1'b0, 1'b0);
		if (wb_req !== '0 || in_ready !== 1'b1)
			report_error("bus request or in_ready wrong after reset");
		set_header(8'd1, 8'd1, 8'h00, 8'h00, 8'h00, 8'h00);
		load_file(1'b1);
		invert_mirroring = 1'b1;
		set_header(8'd2, 8'd1, 8'h49, 8'h18, 8'h35, 8'h00); // iNES 2.0
		load_file(1'b1);
		invert_mirroring = 1'b0;
		set_header(8'd1, 8'd1, 8'h10, 8'h20, 8'h00, 8'h55); // Dirty tail
		load_file(1'b1);
		if (mapper_flags.mapper !== 8'h01)
			report_error("dirty header kept upper mapper nibble");
		set_header(8'd1, 8'd1, 8'h00, 8'h00, 8'h00, 8'h00);
		hdr[1] = 8'h46;
		load_file(1'b0);
		set_header(8'd1, 8'd1, 8'h04, 8'h00, 8'h00, 8'h00); // Trainer
		load_file(1'b0);
		set_header(8'd1, 8'd1, 8'h31, 8'h40, 8'h00, 8'h00);
		load_file(1'b1);
		set_header(8'd1, 8'd0, 8'h00, 8'h00, 8'h00, 8'h00); // CHR RAM
		load_file(1'b1);
		if (mapper_flags.chr_ram !== 1'b1)
			report_error("chr_ram not set for zero CHR pages");
		if (got_adr.size() != 0) begin
			report_error("writes left unchecked");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired because the loader did not finish in time");
		$display("Simulation failed");
		$fatal(1, "watchdog");
	end

endmodule
